//--- logic/csd_cfg.svh
// Touch sense clock generator build configuration for widths, periods and reset values
`ifndef CSD_CFG_SVH
`define CSD_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Prescaler
// ~~~~~~~~~~~~~~~~~~~~

// Width of the prescaler period, compare and count
`define CSD_PRESC_WIDTH 8

// ~~~~~~~~~~~~~~~~~~~~
// Scan speed counter
// ~~~~~~~~~~~~~~~~~~~~

// Terminal value of the scan down counter so one dpulse comes every 32 cycles
`define CSD_SCAN_PERIOD 31
`define CSD_SCAN_WIDTH 5

// ~~~~~~~~~~~~~~~~~~~~
// Pseudo-random sequence
// ~~~~~~~~~~~~~~~~~~~~

`define CSD_PRS_WIDTH 16
`define CSD_PRS_POLY8 8'hB8
`define CSD_PRS_POLY16 16'hB400

// Register values seen by the host right after reset
`define CSD_PERIOD_RESET 8'h0F
`define CSD_COMPARE_RESET 8'h07

`endif

//--- logic/csd_ctrl_pkg.sv
// Control package with the host write port, control word and measurement FSM states
`default_nettype none

package csd_ctrl_pkg;

    // Register address of the host write port
    typedef logic [1:0] reg_addr_t;

    // Register map, address 3 is left unused
    localparam reg_addr_t addr_ctrl    = 2'd0;
    localparam reg_addr_t addr_period  = 2'd1;
    localparam reg_addr_t addr_compare = 2'd2;

    // Host write strobe that lands on the edge where en is high
    typedef struct packed {
        logic       en;
        reg_addr_t  addr;
        logic [7:0] data;
    } reg_wr_t;

    // Control register layout with sync_en in bit 0
    typedef struct packed {
        logic [2:0] spare;
        logic       prs_sel;
        logic       ch1_en;
        logic       ch0_en;
        logic       meas_en;
        logic       sync_en;
    } ctrl_word_t;

    // Idle is all zero and every other state owns one bit of the code
    typedef enum logic [2:0] {
        seq_idle      = 3'b000,
        seq_init      = 3'b001,
        seq_wait_meas = 3'b010,
        seq_run       = 3'b100
    } seq_state_t;

endpackage

`default_nettype wire

//--- logic/csd_clk_pkg.sv
// Clock package with the count and shift register types of the sense clock datapath
`default_nettype none

`include "csd_cfg.svh"

package csd_clk_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Counter types
    // ~~~~~~~~~~~~~~~~~~~~

    // Prescaler period, compare value and running count
    typedef logic [`CSD_PRESC_WIDTH-1:0] presc_count_t;

    // Scan speed down counter
    typedef logic [`CSD_SCAN_WIDTH-1:0] scan_count_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Sequence types
    // ~~~~~~~~~~~~~~~~~~~~

    // Widest pseudo-random state, a narrower generator uses the low bits only
    typedef logic [`CSD_PRS_WIDTH-1:0] prs_state_t;

endpackage

`default_nettype wire

//--- logic/csd_ctrl_regs.sv
// Control registers holding the host-written control word, prescaler period and compare
`timescale 1ns/10ps
`default_nettype none

`include "csd_cfg.svh"

module csd_ctrl_regs
    import csd_ctrl_pkg::*;
    import csd_clk_pkg::*;
(
    input  wire               op_clock,
    input  wire               inter_reset,
    input  wire reg_wr_t      reg_wr,
    output ctrl_word_t        ctrl,
    output presc_count_t      period,
    output presc_count_t      compare
);

    // Writes have no back-pressure and always land on the strobe edge
    // The new value shows on the outputs one cycle later
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            ctrl    <= '0;
            period  <= presc_count_t'(`CSD_PERIOD_RESET);
            compare <= presc_count_t'(`CSD_COMPARE_RESET);
        end
        else if (reg_wr.en)
        begin
            case (reg_wr.addr)
                addr_ctrl:    ctrl    <= ctrl_word_t'(reg_wr.data);
                addr_period:  period  <= presc_count_t'(reg_wr.data);
                addr_compare: compare <= presc_count_t'(reg_wr.data);
                // Nothing lives at address 3
                default:      ;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~

    // Software must not aim a write at the hole in the map while a measurement runs
    a_no_hole_write: assert property (
        @(posedge op_clock) disable iff (inter_reset)
        (reg_wr.en && ctrl.sync_en && ctrl.meas_en) |-> (reg_wr.addr != 2'd3)
    );

endmodule

`default_nettype wire

//--- logic/csd_sequencer.sv
// Measurement sequencer FSM that clears the measurement and gates the channel starts
`timescale 1ns/10ps
`default_nettype none

module csd_sequencer
    import csd_ctrl_pkg::*;
(
    input  wire             op_clock,
    input  wire             inter_reset,
    input  wire ctrl_word_t ctrl,
    output logic            block_reset,
    output logic            mesrst,
    output logic            start0,
    output logic            start1
);

    seq_state_t state;
    seq_state_t next_state;

    // ~~~~~~~~~~~~~~~~~~~~
    // State machine
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            state <= seq_idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    // Idle waits for sync, init is a single cycle, then the FSM waits for the measurement enable
    always_comb
    begin
        next_state = state;
        case (state)
            seq_idle:
            begin
                if (ctrl.sync_en)
                begin
                    next_state = seq_init;
                end
            end
            seq_init:
            begin
                next_state = seq_wait_meas;
            end
            seq_wait_meas:
            begin
                if (ctrl.meas_en)
                begin
                    next_state = seq_run;
                end
            end
            seq_run:
            begin
                // Dropping sync ends the measurement
                if (!ctrl.sync_en)
                begin
                    next_state = seq_idle;
                end
            end
            default:
            begin
                next_state = seq_idle;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Output decode
    // ~~~~~~~~~~~~~~~~~~~~

    // Each output reads one bit of the registered state so there is no added delay
    assign block_reset = (state == seq_init);
    assign mesrst      = (state == seq_wait_meas);
    assign start0      = (state == seq_run) && ctrl.ch0_en;
    assign start1      = (state == seq_run) && ctrl.ch1_en;

    // A channel may only start while the measurement runs
    a_start_in_run: assert property (
        @(posedge op_clock) disable iff (inter_reset)
        (start0 || start1) |-> (state == seq_run)
    );

    // The datapath reset pulse is exactly one cycle wide
    a_block_reset_pulse: assert property (
        @(posedge op_clock) disable iff (inter_reset)
        block_reset |=> !block_reset
    );

endmodule

`default_nettype wire

//--- logic/csd_prescaler.sv
// Prescaler with a reloading down counter that forms the precharge wave and its step strobe
`timescale 1ns/10ps
`default_nettype none

module csd_prescaler
    import csd_clk_pkg::*;
(
    input  wire               op_clock,
    input  wire               inter_reset,
    input  wire               enable,
    input  wire               block_reset,
    input  wire presc_count_t period,
    input  wire presc_count_t compare,
    output logic              presc_wave,
    output logic              step
);

    presc_count_t count;
    // Previous wave level for the rising edge detect
    logic         wave_dly;

    // ~~~~~~~~~~~~~~~~~~~~
    // Counter and wave
    // ~~~~~~~~~~~~~~~~~~~~

    // One wave cycle spans period+1 enabled cycles and is high for compare+1 of them
    // The block reset also clears the wave pipeline so the first step has fixed timing
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            count      <= '0;
            presc_wave <= 1'b0;
            wave_dly   <= 1'b0;
            step       <= 1'b0;
        end
        else if (block_reset)
        begin
            count      <= period;
            presc_wave <= 1'b0;
            wave_dly   <= 1'b0;
            step       <= 1'b0;
        end
        else if (enable)
        begin
            if (count == '0)
            begin
                count <= period;
            end
            else
            begin
                count <= count - 1'b1;
            end
            presc_wave <= (count <= compare);
            wave_dly   <= presc_wave;
            // Step lands one cycle after the wave rises
            step       <= presc_wave && !wave_dly;
        end
        else
        begin
            step <= 1'b0;
        end
    end

    // Step is a strobe and never repeats on the next cycle
    a_step_single: assert property (
        @(posedge op_clock) disable iff (inter_reset)
        step |=> !step
    );

endmodule

`default_nettype wire

//--- logic/csd_prs_gen.sv
// Pseudo-random generator built as a Galois shift register stepped by the prescaler
`timescale 1ns/10ps
`default_nettype none

`include "csd_cfg.svh"

module csd_prs_gen
    import csd_clk_pkg::*;
#(
    parameter int WIDTH = `CSD_PRS_WIDTH
)
(
    input  wire  op_clock,
    input  wire  inter_reset,
    input  wire  enable,
    input  wire  block_reset,
    input  wire  step,
    output logic prs_bit
);

    // Only the low WIDTH bits of the state take part in the sequence
    localparam prs_state_t prs_mask = prs_state_t'((1 << WIDTH) - 1);
    localparam prs_state_t prs_poly = (WIDTH == 8) ? prs_state_t'(`CSD_PRS_POLY8)
                                                   : prs_state_t'(`CSD_PRS_POLY16);

    prs_state_t state;
    prs_state_t shifted;
    logic       msb;

    // Only the two supported widths have a polynomial
    if ((WIDTH != 8) && (WIDTH != 16))
    begin : g_width_check
        $error("csd_prs_gen supports WIDTH of 8 or 16 only");
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Shift register
    // ~~~~~~~~~~~~~~~~~~~~

    assign msb     = state[WIDTH-1];
    assign shifted = (state << 1) & prs_mask;

    // The seed is all ones in the active width
    // A set outgoing MSB folds the polynomial back into the shifted state
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            state <= prs_mask;
        end
        else if (block_reset)
        begin
            state <= prs_mask;
        end
        else if (enable && step)
        begin
            if (msb)
            begin
                state <= shifted ^ prs_poly;
            end
            else
            begin
                state <= shifted;
            end
        end
    end

    assign prs_bit = msb;

    // A zero state would lock the sequence for good
    a_state_nonzero: assert property (
        @(posedge op_clock) disable iff (inter_reset)
        state != '0
    );

endmodule

`default_nettype wire

//--- logic/csd_sense_clocks.sv
// Output stage with the scan speed counter, precharge source select and shield polarity
`timescale 1ns/10ps
`default_nettype none

`include "csd_cfg.svh"

module csd_sense_clocks
    import csd_ctrl_pkg::*;
    import csd_clk_pkg::*;
#(
    parameter bit SHIELD_INVERT = 1'b0
)
(
    input  wire             op_clock,
    input  wire             inter_reset,
    input  wire             enable,
    input  wire             block_reset,
    input  wire ctrl_word_t ctrl,
    input  wire             presc_wave,
    input  wire             prs_bit,
    output logic            dpulse,
    output logic            ppulse,
    output logic            shield
);

    localparam scan_count_t scan_reload = scan_count_t'(`CSD_SCAN_PERIOD);

    scan_count_t scan_count;

    // ~~~~~~~~~~~~~~~~~~~~
    // Scan speed counter
    // ~~~~~~~~~~~~~~~~~~~~

    // Counts down from 31 and reloads at zero for a 32 cycle scan period
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            scan_count <= scan_reload;
        end
        else if (block_reset)
        begin
            scan_count <= scan_reload;
        end
        else if (enable)
        begin
            if (scan_count == '0)
            begin
                scan_count <= scan_reload;
            end
            else
            begin
                scan_count <= scan_count - 1'b1;
            end
        end
    end

    // A held zero count gives no pulse while counting is stopped
    assign dpulse = enable && (scan_count == '0);

    // Precharge comes from the sequence bit or straight from the prescaler wave
    assign ppulse = ctrl.prs_sel ? prs_bit : presc_wave;

    // The shield follows the precharge clock, inverted for a sinking IDAC
    assign shield = ppulse ^ SHIELD_INVERT;

endmodule

`default_nettype wire

//--- logic/csd_clock_gen.sv
// Touch sense clock generator top that connects registers, sequencer and clock datapath
`timescale 1ns/10ps
`default_nettype none

`include "csd_cfg.svh"

module csd_clock_gen
    import csd_ctrl_pkg::*;
    import csd_clk_pkg::*;
#(
    parameter int PRS_WIDTH     = `CSD_PRS_WIDTH,
    parameter bit SHIELD_INVERT = 1'b0
)
(
    input  wire          op_clock,
    input  wire          inter_reset,
    input  wire          enable,
    input  wire reg_wr_t reg_wr,
    output wire          dpulse,
    output wire          ppulse,
    output wire          start0,
    output wire          start1,
    output wire          mesrst,
    output wire          shield
);

    // Host registers
    ctrl_word_t   ctrl;
    presc_count_t period;
    presc_count_t compare;

    // Datapath restart from the sequencer init state
    logic block_reset;

    // Clock datapath
    logic presc_wave;
    logic step;
    logic prs_bit;

    // ~~~~~~~~~~~~~~~~~~~~
    // Control side
    // ~~~~~~~~~~~~~~~~~~~~

    csd_ctrl_regs i_csd_ctrl_regs (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .reg_wr      (reg_wr),
        .ctrl        (ctrl),
        .period      (period),
        .compare     (compare)
    );

    csd_sequencer i_csd_sequencer (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .ctrl        (ctrl),
        .block_reset (block_reset),
        .mesrst      (mesrst),
        .start0      (start0),
        .start1      (start1)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Clock side
    // ~~~~~~~~~~~~~~~~~~~~

    csd_prescaler i_csd_prescaler (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .enable      (enable),
        .block_reset (block_reset),
        .period      (period),
        .compare     (compare),
        .presc_wave  (presc_wave),
        .step        (step)
    );

    csd_prs_gen #(
        .WIDTH (PRS_WIDTH)
    ) i_csd_prs_gen (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .enable      (enable),
        .block_reset (block_reset),
        .step        (step),
        .prs_bit     (prs_bit)
    );

    csd_sense_clocks #(
        .SHIELD_INVERT (SHIELD_INVERT)
    ) i_csd_sense_clocks (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .enable      (enable),
        .block_reset (block_reset),
        .ctrl        (ctrl),
        .presc_wave  (presc_wave),
        .prs_bit     (prs_bit),
        .dpulse      (dpulse),
        .ppulse      (ppulse),
        .shield      (shield)
    );

endmodule

`default_nettype wire

//--- tb/csd_tb_tasks.svh
// Directed test tasks, compare tasks and shift register reference model for the testbench
`ifndef CSD_TB_TASKS_SVH
`define CSD_TB_TASKS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Bus and compare helpers
// ~~~~~~~~~~~~~~~~~~~~

// Outputs are sampled here first, then new inputs are driven in the same step
task automatic next_cycle();
    @(posedge op_clock);
    #1;
endtask

// A write strobe lasts one cycle and the register shows the value on return
task automatic write_reg(input reg_addr_t addr, input logic [7:0] data);
    reg_wr.en   = 1'b1;
    reg_wr.addr = addr;
    reg_wr.data = data;
    next_cycle();
    reg_wr.en = 1'b0;
endtask

function automatic ctrl_word_t make_ctrl(input logic sync, input logic meas,
                                         input logic ch0, input logic ch1, input logic prs);
    ctrl_word_t word;
    word         = '0;
    word.sync_en = sync;
    word.meas_en = meas;
    word.ch0_en  = ch0;
    word.ch1_en  = ch1;
    word.prs_sel = prs;
    return word;
endfunction

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
        abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
endtask

task automatic check_count(input string name, input presc_count_t got, input presc_count_t exp);
    if (got !== exp)
    begin
        abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
endtask

// Galois step: shift left and fold in the polynomial when the old MSB was set
function automatic prs_state_t prs_model_step(input prs_state_t state);
    prs_state_t shifted;
    shifted = state << 1;
    if (state[prs_width-1])
    begin
        shifted = shifted ^ prs_state_t'(`CSD_PRS_POLY16);
    end
    return shifted;
endfunction

// ~~~~~~~~~~~~~~~~~~~~
// Waveform measurement
// ~~~~~~~~~~~~~~~~~~~~

task automatic wait_dpulse();
    int cycles;
    cycles = 0;
    while (dpulse !== 1'b1)
    begin
        if (cycles > scan_cycles + 4)
        begin
            abort_run("No dpulse appeared within one scan period");
        end
        next_cycle();
        cycles++;
    end
endtask

// Counts cycles to the next dpulse and holds enable low for gap_len cycles on the way
task automatic measure_dpulse_gap(input int gap_start, input int gap_len, output int cycles);
    logic hit;
    cycles = 0;
    hit    = 1'b0;
    while (!hit)
    begin
        next_cycle();
        cycles++;
        hit = (dpulse === 1'b1);
        if (cycles > scan_cycles + gap_len + 8)
        begin
            abort_run("dpulse went missing while measuring the scan interval");
        end
        if ((gap_len > 0) && (cycles == gap_start))
        begin
            enable = 1'b0;
        end
        if (cycles == gap_start + gap_len)
        begin
            enable = 1'b1;
        end
    end
endtask

// Returns on the first sample where ppulse is high after being low
task automatic wait_ppulse_rise();
    logic prev;
    logic cur;
    int   cycles;
    prev   = ppulse;
    cur    = ppulse;
    cycles = 0;
    while (!((prev === 1'b0) && (cur === 1'b1)))
    begin
        if (cycles > wave_limit)
        begin
            abort_run("ppulse did not rise within two prescaler periods");
        end
        prev = cur;
        next_cycle();
        cur = ppulse;
        cycles++;
    end
endtask

// Starts on a rise sample and stops on the next one
// The shield is compared on every cycle in between
task automatic measure_wave(output int high_len, output int total_len);
    high_len  = 0;
    total_len = 0;
    while ((ppulse === 1'b1) && (total_len <= wave_limit))
    begin
        check_bit("shield", shield, ppulse ^ shield_invert);
        high_len++;
        total_len++;
        next_cycle();
    end
    while ((ppulse === 1'b0) && (total_len <= wave_limit))
    begin
        check_bit("shield", shield, ppulse ^ shield_invert);
        total_len++;
        next_cycle();
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~
// Directed tests
// ~~~~~~~~~~~~~~~~~~~~

// The scan count starts at 31 on the release cycle and reaches 0 after 31 edges
task automatic reset_outputs_low();
    int idx;
    for (idx = 0; idx < `CSD_SCAN_PERIOD; idx++)
    begin
        check_bit("dpulse", dpulse, 1'b0);
        check_bit("start0", start0, 1'b0);
        check_bit("start1", start1, 1'b0);
        check_bit("mesrst", mesrst, 1'b0);
        next_cycle();
    end
    check_bit("dpulse", dpulse, 1'b1);
endtask

task automatic sequencer_steps();
    write_reg(addr_ctrl, make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    // One cycle in init before the measurement clear shows
    next_cycle();
    check_bit("mesrst", mesrst, 1'b0);
    next_cycle();
    check_bit("mesrst", mesrst, 1'b1);
    check_bit("start0", start0, 1'b0);
    check_bit("start1", start1, 1'b0);
    write_reg(addr_ctrl, make_ctrl(1'b1, 1'b1, 1'b1, 1'b0, 1'b0));
    next_cycle();
    check_bit("mesrst", mesrst, 1'b0);
    check_bit("start0", start0, 1'b1);
    check_bit("start1", start1, 1'b0);
    // The second channel follows its enable bit straight away while the FSM runs
    write_reg(addr_ctrl, make_ctrl(1'b1, 1'b1, 1'b1, 1'b1, 1'b0));
    check_bit("start0", start0, 1'b1);
    check_bit("start1", start1, 1'b1);
    // Dropping sync sends the FSM back to idle on the next edge
    write_reg(addr_ctrl, make_ctrl(1'b0, 1'b1, 1'b1, 1'b1, 1'b0));
    next_cycle();
    check_bit("start0", start0, 1'b0);
    check_bit("start1", start1, 1'b0);
endtask

task automatic scan_pulse_timing();
    int gap_len;
    int interval;
    gap_len = 1 + ($urandom % 20);
    wait_dpulse();
    measure_dpulse_gap(0, 0, interval);
    check_count("dpulse interval", presc_count_t'(interval), presc_count_t'(scan_cycles));
    // A stopped stretch pushes the next pulse out by its own length
    measure_dpulse_gap(10, gap_len, interval);
    check_count("dpulse interval", presc_count_t'(interval),
                presc_count_t'(scan_cycles + gap_len));
endtask

task automatic prescaler_duty();
    int high_len;
    int total_len;
    int rep;
    cur_period  = presc_count_t'(4 + ($urandom % (max_period - 3)));
    cur_compare = presc_count_t'($urandom % cur_period);
    write_reg(addr_ctrl, make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    write_reg(addr_period, cur_period);
    write_reg(addr_compare, cur_compare);
    // Two rises flush the wave cycle that ran during the writes
    wait_ppulse_rise();
    wait_ppulse_rise();
    for (rep = 0; rep < 2; rep++)
    begin
        measure_wave(high_len, total_len);
        check_count("ppulse high", presc_count_t'(high_len), cur_compare + 1'b1);
        check_count("ppulse period", presc_count_t'(total_len), cur_period + 1'b1);
    end
endtask

task automatic prs_sequence();
    prs_state_t model;
    int         step_idx;
    model = '1;
    write_reg(addr_ctrl, make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
    // Init cycle, then the datapath restarts from the seed and a full period count
    next_cycle();
    next_cycle();
    // First step comes period-compare+2 cycles after release and shifts one edge later
    repeat (cur_period - cur_compare + 3) next_cycle();
    repeat ((cur_period + 1) / 2) next_cycle();
    for (step_idx = 0; step_idx < 40; step_idx++)
    begin
        model = prs_model_step(model);
        check_bit("ppulse", ppulse, model[prs_width-1]);
        repeat (cur_period + 1) next_cycle();
    end
endtask

`endif

//--- tb/csd_clock_gen_tb.sv
// Testbench top for the touch sense clock generator with clock, reset, watchdog and test order
`timescale 1ns/10ps
`default_nettype none

`include "csd_cfg.svh"

module csd_clock_gen_tb
    import csd_ctrl_pkg::*;
    import csd_clk_pkg::*;
();

    localparam int clk_period    = 8;
    localparam int reset_cycles  = 8;
    localparam int prs_width     = 16;
    localparam bit shield_invert = 1'b0;

    // Random prescaler periods stay at or below this value
    localparam int max_period  = 48;
    localparam int scan_cycles = `CSD_SCAN_PERIOD + 1;
    // One wave search may span the old cycle and one full new cycle
    localparam int wave_limit  = 2 * (max_period + 2);

    // ~~~~~~~~~~~~~~~~~~~~
    // Run time budget
    // ~~~~~~~~~~~~~~~~~~~~

    // Reset, the idle scan window, the sequencer writes and the three scan intervals
    localparam int early_cycles = reset_cycles + scan_cycles + 20 + 4 * (scan_cycles + 24);
    // Two flushed and two measured wave cycles, then 40 sequence samples plus the start
    localparam int clock_cycles = 6 * (max_period + 1) + 42 * (max_period + 1);
    localparam int watchdog_cycles = early_cycles + clock_cycles + 200;

    logic         op_clock;
    logic         inter_reset;
    logic         enable;
    reg_wr_t      reg_wr;
    wire          dpulse;
    wire          ppulse;
    wire          start0;
    wire          start1;
    wire          mesrst;
    wire          shield;

    // Prescaler setting picked in the prescaler test and reused in sequence mode
    presc_count_t cur_period;
    presc_count_t cur_compare;

    csd_clock_gen #(
        .PRS_WIDTH     (prs_width),
        .SHIELD_INVERT (shield_invert)
    ) i_csd_clock_gen (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .enable      (enable),
        .reg_wr      (reg_wr),
        .dpulse      (dpulse),
        .ppulse      (ppulse),
        .start0      (start0),
        .start1      (start1),
        .mesrst      (mesrst),
        .shield      (shield)
    );

    // Every failure path ends here
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    `include "csd_tb_tasks.svh"

    // ~~~~~~~~~~~~~~~~~~~~
    // Clock and watchdog
    // ~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        op_clock = 1'b0;
        forever #(clk_period / 2) op_clock = ~op_clock;
    end

    initial
    begin
        #(watchdog_cycles * clk_period);
        abort_run("Watchdog expired before the directed tests finished");
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Test order
    // ~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        void'($urandom(32'hec4a_d3a1));
        inter_reset = 1'b1;
        // Counting is enabled from the start, reset holds the counters anyway
        enable      = 1'b1;
        reg_wr      = '0;
        cur_period  = '0;
        cur_compare = '0;
        repeat (reset_cycles) next_cycle();
        inter_reset = 1'b0;

        reset_outputs_low();
        sequencer_steps();
        scan_pulse_timing();
        prescaler_duty();
        prs_sequence();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+logic
+incdir+tb
logic/csd_ctrl_pkg.sv
logic/csd_clk_pkg.sv
logic/csd_ctrl_regs.sv
logic/csd_sequencer.sv
logic/csd_prescaler.sv
logic/csd_prs_gen.sv
logic/csd_sense_clocks.sv
logic/csd_clock_gen.sv
tb/csd_clock_gen_tb.sv
